// File: hw/soc_cfg_pkg.sv
// soc configuration package with the memory geometry of the loader RAM banks
`default_nettype none

package soc_cfg_pkg;

localparam int XLEN           = 32;                     // width of the loader address register
localparam int BYTE_LANES     = 4;
localparam int LANE_W         = $clog2(BYTE_LANES);
localparam int MEM_REGIONS    = 2;                      // region 0 is iram, region 1 is dram
localparam int BANK_COUNT     = MEM_REGIONS * BYTE_LANES;
localparam int WORD_ADDR_W    = 8;
localparam int WORDS_PER_BANK = 2 ** WORD_ADDR_W;

// byte address bits 1..0 pick the lane and bits 9..2 the word, higher bits wrap
typedef logic [7:0]             byte_t;
typedef logic [WORD_ADDR_W-1:0] word_addr_t;
typedef logic [LANE_W-1:0]      lane_t;

endpackage

`default_nettype wire

// File: hw/loader_cmd_pkg.sv
// loader command package with the host command codes and the loader state type
`default_nettype none

package loader_cmd_pkg;

localparam logic [7:0] CMD_IRAM_WR = 8'h01;
localparam logic [7:0] CMD_IRAM_RD = 8'h02;
localparam logic [7:0] CMD_DRAM_WR = 8'h03;
localparam logic [7:0] CMD_DRAM_RD = 8'h04;
localparam logic [7:0] CMD_RUN     = 8'h05;     // releases the core from reset

localparam int ADDR_BYTES = 4;                  // address is sent lsb first
localparam int ADDR_CNT_W = $clog2(ADDR_BYTES);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_STREAM
} loader_state_e;

endpackage

`default_nettype wire

// File: hw/spi_slave.sv
// spi slave, oversamples mode 0 pins in the system clock domain and moves bytes in and out
`default_nettype none

module spi_slave
    import soc_cfg_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    input  logic  spi_sclk_i,
    input  logic  spi_mosi_i,
    input  logic  spi_cs_n_i,

    input  byte_t spi_byte_data_i,

    output logic  spi_miso_o,

    output logic  spi_byte_vld_o,
    output byte_t spi_byte_data_o
);

logic [2:0] sclk_r;     // two sync stages plus one for edge detection
logic [2:0] cs_n_r;
logic [1:0] mosi_r;

logic sclk_rise;
logic sclk_fall;
logic cs_n_rise;
logic cs_n_fall;
logic cs_act;

logic [2:0] bit_cnt;
logic       byte_done;  // set after the eighth bit until the next falling sclk
byte_t      rx_shift;
byte_t      tx_shift;

assign sclk_rise  = sclk_r[1] & ~sclk_r[2];
assign sclk_fall  = ~sclk_r[1] & sclk_r[2];
assign cs_n_rise  = cs_n_r[1] & ~cs_n_r[2];
assign cs_n_fall  = ~cs_n_r[1] & cs_n_r[2];
assign cs_act     = ~cs_n_r[1];
assign spi_miso_o = tx_shift[7];

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        sclk_r <= '0;
        cs_n_r <= '1;
        mosi_r <= '0;
    end else begin
        sclk_r <= {sclk_r[1:0], spi_sclk_i};
        cs_n_r <= {cs_n_r[1:0], spi_cs_n_i};
        mosi_r <= {mosi_r[0], spi_mosi_i};
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        bit_cnt        <= '0;
        byte_done      <= 1'b0;
        spi_byte_vld_o <= 1'b0;
    end else begin
        spi_byte_vld_o <= 1'b0;
        if (cs_n_rise) begin
            bit_cnt   <= '0;                // a partial byte is dropped here
            byte_done <= 1'b0;
        end else if (cs_act && sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                spi_byte_vld_o <= 1'b1;
                byte_done      <= 1'b1;
            end
        end else if (cs_act && sclk_fall) begin
            byte_done <= 1'b0;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (cs_act && sclk_rise) begin
        rx_shift <= {rx_shift[6:0], mosi_r[1]};     // msb first
        if (bit_cnt == 3'd7) begin
            spi_byte_data_o <= {rx_shift[6:0], mosi_r[1]};
        end
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        tx_shift <= '0;
    end else if (cs_n_fall || (cs_act && sclk_fall && byte_done)) begin
        tx_shift <= spi_byte_data_i;                // msb goes out right at load
    end else if (cs_act && sclk_fall) begin
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
end

endmodule

`default_nettype wire

// File: hw/ram_loader.sv
// ram loader, decodes host commands and streams bytes into and out of the RAM banks
`default_nettype none

module ram_loader
    import soc_cfg_pkg::*;
    import loader_cmd_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  dc_i,

    input  logic                  spi_byte_vld_i,
    input  byte_t                 spi_byte_data_i,

    output logic                  cpu_rst_n_o,

    output logic [BANK_COUNT-1:0] bank_sel_o,
    output logic                  bank_wr_en_o,
    output word_addr_t            bank_addr_o,
    output byte_t                 bank_wr_data_o,

    output lane_t                 rd_lane_o,
    output logic                  rd_region_o,

    output logic                  led_iram_o,
    output logic                  led_dram_o
);

loader_state_e state;

logic                  region_q;
logic                  rd_mode_q;
logic [ADDR_CNT_W-1:0] addr_cnt;
logic [XLEN-1:0]       addr_q;

logic            cmd_vld;
logic            data_vld;
logic            cmd_access;
logic            cmd_region;
logic            cmd_read;
logic            last_addr;
logic            issue_wr;
logic            issue_rd;
logic [XLEN-1:0] addr_shift;
logic [XLEN-1:0] addr_inc;
logic [XLEN-1:0] access_addr;
lane_t           access_lane;

assign cmd_vld  = spi_byte_vld_i & ~dc_i;
assign data_vld = spi_byte_vld_i & dc_i;

always_comb begin
    cmd_access = 1'b1;
    cmd_region = 1'b0;
    cmd_read   = 1'b0;
    case (spi_byte_data_i)
        CMD_IRAM_WR: cmd_read = 1'b0;
        CMD_IRAM_RD: cmd_read = 1'b1;
        CMD_DRAM_WR: cmd_region = 1'b1;
        CMD_DRAM_RD: begin
            cmd_region = 1'b1;
            cmd_read   = 1'b1;
        end
        default: cmd_access = 1'b0;     // run and unknown codes close the access
    endcase
end

assign addr_shift = {spi_byte_data_i, addr_q[XLEN-1:8]};
assign addr_inc   = addr_q + 1'b1;
assign last_addr  = (state == ST_ADDR) && (addr_cnt == ADDR_CNT_W'(ADDR_BYTES - 1));

// reads prefetch the next byte, writes use the current address
assign issue_rd = data_vld & rd_mode_q & (last_addr | (state == ST_STREAM));
assign issue_wr = data_vld & ~rd_mode_q & (state == ST_STREAM);

assign access_addr = (state == ST_ADDR) ? addr_shift : (rd_mode_q ? addr_inc : addr_q);
assign access_lane = access_addr[LANE_W-1:0];

assign led_iram_o = (state != ST_IDLE) & ~region_q;
assign led_dram_o = (state != ST_IDLE) & region_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state       <= ST_IDLE;
        region_q    <= 1'b0;
        rd_mode_q   <= 1'b0;
        addr_cnt    <= '0;
        cpu_rst_n_o <= 1'b0;
    end else if (cmd_vld) begin
        state       <= cmd_access ? ST_ADDR : ST_IDLE;
        region_q    <= cmd_region;
        rd_mode_q   <= cmd_read;
        addr_cnt    <= '0;
        cpu_rst_n_o <= (spi_byte_data_i == CMD_RUN);
    end else if (data_vld && state == ST_ADDR) begin
        addr_cnt <= addr_cnt + 1'b1;
        if (last_addr) begin
            state <= ST_STREAM;
        end
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        bank_sel_o   <= '0;
        bank_wr_en_o <= 1'b0;
    end else begin
        bank_sel_o   <= '0;
        bank_wr_en_o <= 1'b0;
        if (issue_wr || issue_rd) begin
            bank_sel_o   <= BANK_COUNT'(1) << {region_q, access_lane};
            bank_wr_en_o <= issue_wr;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (data_vld && state == ST_ADDR) begin
        addr_q <= addr_shift;
    end else if (data_vld && state == ST_STREAM) begin
        addr_q <= addr_inc;
    end
    if (issue_wr || issue_rd) begin
        bank_addr_o    <= access_addr[LANE_W +: WORD_ADDR_W];
        bank_wr_data_o <= spi_byte_data_i;
    end
    if (issue_rd) begin
        rd_lane_o   <= access_lane;
        rd_region_o <= region_q;
    end
end

endmodule

`default_nettype wire

// File: hw/ram_bank.sv
// ram bank, one byte lane of single-port memory with a registered read
`default_nettype none

module ram_bank
    import soc_cfg_pkg::*;
(
    input  logic       clk_i,

    input  logic       sel_i,
    input  logic       wr_en_i,

    input  word_addr_t addr_i,
    input  byte_t      wr_data_i,

    output byte_t      rd_data_o
);

byte_t mem [WORDS_PER_BANK];

always_ff @(posedge clk_i) begin
    if (sel_i) begin
        if (wr_en_i) begin
            mem[addr_i] <= wr_data_i;
        end else begin
            rd_data_o <= mem[addr_i];   // holds until the next read of this bank
        end
    end
end

endmodule

`default_nettype wire

// File: hw/ram_rd_mux.sv
// ram read mux, picks the byte of the bank that the last read addressed
`default_nettype none

module ram_rd_mux
    import soc_cfg_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  lane_t                  rd_lane_i,
    input  logic                   rd_region_i,

    input  byte_t [BANK_COUNT-1:0] bank_rd_data_i,

    output byte_t                  rd_data_o
);

lane_t lane_q;
logic  region_q;

// captured on the same edge as the bank read data
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        lane_q   <= '0;
        region_q <= 1'b0;
    end else begin
        lane_q   <= rd_lane_i;
        region_q <= rd_region_i;
    end
end

assign rd_data_o = bank_rd_data_i[{region_q, lane_q}];   // bank index is region * 4 + lane

endmodule

`default_nettype wire

// File: hw/ram_load_top.sv
// ram load top, spi program loader with instruction and data RAM banks
`default_nettype none

module ram_load_top
    import soc_cfg_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic dc_i,

    input  logic spi_sclk_i,
    input  logic spi_mosi_i,
    input  logic spi_cs_n_i,

    output logic spi_miso_o,

    output logic cpu_rst_n_o,

    output logic led_iram_o,
    output logic led_dram_o
);

logic                   spi_byte_vld;
byte_t                  spi_byte_data;

logic [BANK_COUNT-1:0]  bank_sel;
logic                   bank_wr_en;
word_addr_t             bank_addr;
byte_t                  bank_wr_data;
byte_t [BANK_COUNT-1:0] bank_rd_data;

lane_t                  rd_lane;
logic                   rd_region;
byte_t                  rd_data;

spi_slave u_spi_slave (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .spi_sclk_i      (spi_sclk_i),
    .spi_mosi_i      (spi_mosi_i),
    .spi_cs_n_i      (spi_cs_n_i),
    .spi_byte_data_i (rd_data),
    .spi_miso_o      (spi_miso_o),
    .spi_byte_vld_o  (spi_byte_vld),
    .spi_byte_data_o (spi_byte_data)
);

ram_loader u_ram_loader (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .dc_i            (dc_i),
    .spi_byte_vld_i  (spi_byte_vld),
    .spi_byte_data_i (spi_byte_data),
    .cpu_rst_n_o     (cpu_rst_n_o),
    .bank_sel_o      (bank_sel),
    .bank_wr_en_o    (bank_wr_en),
    .bank_addr_o     (bank_addr),
    .bank_wr_data_o  (bank_wr_data),
    .rd_lane_o       (rd_lane),
    .rd_region_o     (rd_region),
    .led_iram_o      (led_iram_o),
    .led_dram_o      (led_dram_o)
);

for (genvar r = 0; r < MEM_REGIONS; r++) begin : g_region
    for (genvar l = 0; l < BYTE_LANES; l++) begin : g_lane
        ram_bank u_ram_bank (
            .clk_i     (clk_i),
            .sel_i     (bank_sel[r*BYTE_LANES+l]),
            .wr_en_i   (bank_wr_en),
            .addr_i    (bank_addr),
            .wr_data_i (bank_wr_data),
            .rd_data_o (bank_rd_data[r*BYTE_LANES+l])
        );
    end
end

ram_rd_mux u_ram_rd_mux (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rd_lane_i      (rd_lane),
    .rd_region_i    (rd_region),
    .bank_rd_data_i (bank_rd_data),
    .rd_data_o      (rd_data)
);

endmodule

`default_nettype wire

// File: verification/ram_load_top_chk.sv
// assertion checker for the ram loader top, watches leds, bank selects and the spi byte strobe
`default_nettype none

module ram_load_top_chk
    import soc_cfg_pkg::*;
(
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  spi_cs_n_i,
    input logic                  spi_byte_vld_i,
    input logic [BANK_COUNT-1:0] bank_sel_i,
    input logic                  bank_wr_en_i,
    input logic                  cpu_rst_n_i,
    input logic                  led_iram_i,
    input logic                  led_dram_i
);

timeunit 1ns;
timeprecision 100ps;

a_led_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(led_iram_i && led_dram_i))
    else $error("led_iram_o and led_dram_o are high together");

// the core owns the memories once it runs
a_no_sel_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpu_rst_n_i |-> (bank_sel_i == '0))
    else $error("a bank is selected while cpu_rst_n_o is high");

a_vld_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    spi_byte_vld_i |=> !spi_byte_vld_i)
    else $error("spi_byte_vld is longer than one cycle");

a_wr_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bank_wr_en_i |-> !spi_cs_n_i)
    else $error("bank write enable while spi_cs_n_i is high");

endmodule

bind ram_load_top ram_load_top_chk u_ram_load_top_chk (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .spi_cs_n_i     (spi_cs_n_i),
    .spi_byte_vld_i (spi_byte_vld),
    .bank_sel_i     (bank_sel),
    .bank_wr_en_i   (bank_wr_en),
    .cpu_rst_n_i    (cpu_rst_n_o),
    .led_iram_i     (led_iram_o),
    .led_dram_i     (led_dram_o)
);

`default_nettype wire

// File: verification/tb_ram_load_top.sv
// testbench for the spi ram loader, plays the spi host and checks read data, leds and core reset
`default_nettype none

module tb_ram_load_top
    import soc_cfg_pkg::*;
    import loader_cmd_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int HALF_CYCLES  = 8;                            // sclk half period in clk cycles
localparam int REGION_BYTES = BYTE_LANES * WORDS_PER_BANK;  // byte addresses wrap at this size
localparam int DRAIN_LIMIT  = 2000;

logic clk;
logic rst_n;
logic dc;
logic spi_sclk;
logic spi_mosi;
logic spi_cs_n;
logic spi_miso;
logic cpu_rst_n;
logic led_iram;
logic led_dram;

byte_t       ref_mem [MEM_REGIONS][REGION_BYTES];
byte_t       got_q [$];
byte_t       exp_q [$];
int          data_err    = 0;
int          status_err  = 0;
int          timeout_err = 0;
int unsigned seed_val;

ram_load_top u_ram_load_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .dc_i        (dc),
    .spi_sclk_i  (spi_sclk),
    .spi_mosi_i  (spi_mosi),
    .spi_cs_n_i  (spi_cs_n),
    .spi_miso_o  (spi_miso),
    .cpu_rst_n_o (cpu_rst_n),
    .led_iram_o  (led_iram),
    .led_dram_o  (led_dram)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic byte_t expected_byte(input logic region, input logic [XLEN-1:0] addr);
    int unsigned idx;
    idx = addr % REGION_BYTES;      // only bits 9..0 reach the banks
    return ref_mem[region][idx];
endfunction

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        data_err++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        status_err++;
    end
endtask

task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #10;
endtask

task automatic spi_xfer(input logic dc_lvl, input byte_t tx, output byte_t rx);
    dc = dc_lvl;
    for (int i = 7; i >= 0; i--) begin
        spi_mosi = tx[i];
        tick(HALF_CYCLES);
        spi_sclk = 1'b1;
        rx[i]    = spi_miso;        // mode 0 host samples on the rising edge
        tick(HALF_CYCLES);
        spi_sclk = 1'b0;
    end
endtask

task automatic cs_low();
    spi_cs_n = 1'b0;
    tick(HALF_CYCLES);
endtask

task automatic cs_high();
    tick(HALF_CYCLES);
    spi_cs_n = 1'b1;
    tick(HALF_CYCLES);
endtask

task automatic open_access(input byte_t cmd, input logic [XLEN-1:0] addr);
    byte_t rx;
    logic  is_dram;
    is_dram = (cmd == CMD_DRAM_WR) || (cmd == CMD_DRAM_RD);
    cs_low();
    spi_xfer(1'b0, cmd, rx);
    check_bit("led_iram_o", led_iram, ~is_dram);
    check_bit("led_dram_o", led_dram, is_dram);
    check_bit("cpu_rst_n_o", cpu_rst_n, 1'b0);
    for (int i = 0; i < ADDR_BYTES; i++) begin
        spi_xfer(1'b1, addr[8*i +: 8], rx);
    end
endtask

task automatic write_bytes(input logic region, input logic [XLEN-1:0] addr, input int n);
    byte_t       rx;
    byte_t       val;
    int unsigned idx;
    for (int k = 0; k < n; k++) begin
        idx = (addr + k) % REGION_BYTES;
        val = byte_t'($urandom);
        if (val == ref_mem[~region][idx]) begin
            val = ~val;             // the other region must hold a different byte here
        end
        spi_xfer(1'b1, val, rx);
        ref_mem[region][idx] = val;
    end
endtask

task automatic read_bytes(input logic region, input logic [XLEN-1:0] addr, input int n);
    byte_t rx;
    for (int k = 0; k < n; k++) begin
        spi_xfer(1'b1, 8'h00, rx);
        got_q.push_back(rx);
        exp_q.push_back(expected_byte(region, addr + k));
    end
endtask

task automatic write_burst(input logic region, input logic [XLEN-1:0] addr, input int n);
    open_access(region ? CMD_DRAM_WR : CMD_IRAM_WR, addr);
    write_bytes(region, addr, n);
    cs_high();
endtask

task automatic read_burst(input logic region, input logic [XLEN-1:0] addr, input int n);
    open_access(region ? CMD_DRAM_RD : CMD_IRAM_RD, addr);
    read_bytes(region, addr, n);
    cs_high();
endtask

task automatic run_core();
    byte_t rx;
    cs_low();
    spi_xfer(1'b0, CMD_RUN, rx);
    cs_high();
    check_bit("cpu_rst_n_o", cpu_rst_n, 1'b1);
    check_bit("led_iram_o", led_iram, 1'b0);
    check_bit("led_dram_o", led_dram, 1'b0);
endtask

// a few clocks of a byte, then cs goes high before the eighth bit
task automatic partial_byte(input int bits);
    for (int i = 0; i < bits; i++) begin
        spi_mosi = 1'b1;
        tick(HALF_CYCLES);
        spi_sclk = 1'b1;
        tick(HALF_CYCLES);
        spi_sclk = 1'b0;
    end
    cs_high();
endtask

task automatic drain_compare();
    int cycles;
    cycles = 0;
    while (got_q.size() != 0 && cycles < DRAIN_LIMIT) begin
        @(posedge clk);
        cycles++;
    end
    if (got_q.size() != 0) begin
        $display("timeout while waiting for the read bytes to be compared");
        timeout_err++;
    end
endtask

initial begin : compare_proc
    byte_t got;
    byte_t exp;
    forever begin
        @(posedge clk);
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_byte("spi_miso_o", got, exp);
        end
    end
end

initial begin
    seed_val = $urandom(32'h6859063a);
    rst_n    = 1'b0;
    dc       = 1'b0;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    spi_cs_n = 1'b1;
    tick(5);
    rst_n = 1'b1;
    tick(2);
    check_bit("cpu_rst_n_o", cpu_rst_n, 1'b0);
    check_bit("led_iram_o", led_iram, 1'b0);
    check_bit("led_dram_o", led_dram, 1'b0);

    write_burst(1'b0, 32'h0000_0010, 24);
    read_burst(1'b0, 32'h0000_0010, 24);

    write_burst(1'b1, 32'h0000_0010, 24);
    read_burst(1'b0, 32'h0000_0010, 24);
    read_burst(1'b1, 32'h0000_0010, 24);

    write_burst(1'b0, 32'd1020, 8);     // crosses 1023 into 0
    read_burst(1'b0, 32'd1020, 8);
    read_burst(1'b0, 32'h0000_0000, 4);
    read_burst(1'b0, 32'h0001_0400, 4);

    run_core();
    write_burst(1'b1, 32'h0000_0200, 4);
    read_burst(1'b1, 32'h0000_0200, 4);

    open_access(CMD_DRAM_WR, 32'h0000_0300);
    write_bytes(1'b1, 32'h0000_0300, 2);
    partial_byte(3);
    cs_low();
    write_bytes(1'b1, 32'h0000_0302, 2);
    cs_high();
    read_burst(1'b1, 32'h0000_0300, 4);

    drain_compare();
    $display("read data errors %0d, status errors %0d, timeouts %0d",
             data_err, status_err, timeout_err);
    if (data_err + status_err + timeout_err == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: compile.f
hw/soc_cfg_pkg.sv
hw/loader_cmd_pkg.sv
hw/spi_slave.sv
hw/ram_loader.sv
hw/ram_bank.sv
hw/ram_rd_mux.sv
hw/ram_load_top.sv
verification/ram_load_top_chk.sv
verification/tb_ram_load_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the ram loader testbench with verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_ram_load_top -f compile.f -o tb_ram_load_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_ram_load_top > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
